// ==== axi_rd_defines.svh ====
`ifndef AXI_RD_DEFINES_SVH
`define AXI_RD_DEFINES_SVH

// ------------------------------------------------------------------------
// AXI read subordinate widths and defaults
// ------------------------------------------------------------------------

// Byte address width
`define AXI_RD_AW 32

// Data bus width, also the component word width
`define AXI_RD_DW 32

// Transaction ID width
`define AXI_RD_IW 4

// AxLEN field, beats minus one
`define AXI_RD_LEN_W 8

// AxSIZE field, log2 of bytes per beat
`define AXI_RD_SIZE_W 3

// Cycles from a taken component request to its rdata
`define AXI_RD_C_LAT_DEFAULT 1

`endif

// ==== axi_rd_pkg.sv ====
package axi_rd_pkg;

`include "axi_rd_defines.svh"

    // ------------------------------------------------------------------------
    // Scalar field types
    // ------------------------------------------------------------------------
    typedef logic [`AXI_RD_AW-1:0]     addr_t;
    typedef logic [`AXI_RD_DW-1:0]     data_t;
    typedef logic [`AXI_RD_IW-1:0]     id_t;
    typedef logic [`AXI_RD_LEN_W-1:0]  len_t;
    typedef logic [`AXI_RD_SIZE_W-1:0] size_t;

    // AxBURST encoding
    typedef enum logic [1:0] {
        BURST_FIXED    = 2'b00,
        BURST_INCR     = 2'b01,
        BURST_WRAP     = 2'b10,
        BURST_RESERVED = 2'b11
    } burst_e;

    // xRESP encoding, EXOKAY kept only for completeness of the field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // ------------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------------

    // AR channel payload
    typedef struct packed {
        addr_t  addr;
        burst_e burst;
        size_t  size;
        len_t   len;
        id_t    id;
    } ar_req_t;

    // Request towards the component, addr is word aligned
    typedef struct packed {
        addr_t addr;
        id_t   id;
        size_t size;
        logic  last;
    } comp_req_t;

    // Context riding along with a beat while the component answers
    typedef struct packed {
        id_t  id;
        logic last;
    } xfer_ctx_t;

    // R channel payload
    typedef struct packed {
        data_t data;
        id_t   id;
        resp_e resp;
        logic  last;
    } r_rsp_t;

endpackage

// ==== axi_rd_addr_gen.sv ====
`timescale 1ns/1ps

module axi_rd_addr_gen (
    input  axi_rd_pkg::addr_t  i_addr,
    input  axi_rd_pkg::size_t  i_size,
    input  axi_rd_pkg::burst_e i_burst,
    input  axi_rd_pkg::len_t   i_len,
    output axi_rd_pkg::addr_t  o_next_addr
);

    // Bytes moved by one beat
    axi_rd_pkg::addr_t beat_bytes;
    // Current address aligned down to the beat size
    axi_rd_pkg::addr_t aligned_addr;
    // Plain incrementing successor
    axi_rd_pkg::addr_t incr_addr;
    // Wrap window, size times beat count
    axi_rd_pkg::addr_t wrap_bytes;
    axi_rd_pkg::addr_t wrap_mask;
    axi_rd_pkg::addr_t wrap_base;
    axi_rd_pkg::addr_t wrap_addr;

    // ------------------------------------------------------------------------
    // Beat and window arithmetic
    // ------------------------------------------------------------------------
    assign beat_bytes   = axi_rd_pkg::addr_t'(1) << i_size;
    assign aligned_addr = i_addr & ~(beat_bytes - axi_rd_pkg::addr_t'(1));
    assign incr_addr    = aligned_addr + beat_bytes;

    // Legal wrap lengths are 2, 4, 8 or 16 so the window is a power of two
    assign wrap_bytes = (axi_rd_pkg::addr_t'(i_len) + axi_rd_pkg::addr_t'(1)) << i_size;
    assign wrap_mask  = wrap_bytes - axi_rd_pkg::addr_t'(1);
    assign wrap_base  = i_addr & ~wrap_mask;
    // Offset rolls over inside the window, back to base at the top
    assign wrap_addr  = wrap_base | (incr_addr & wrap_mask);

    // ------------------------------------------------------------------------
    // Next address select
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_burst)
            axi_rd_pkg::BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            axi_rd_pkg::BURST_WRAP: begin
                o_next_addr = wrap_addr;
            end
            // FIXED repeats the address, RESERVED treated the same
            default: begin
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

// ==== axi_rd_burst_ctrl.sv ====
`timescale 1ns/1ps

`include "axi_rd_defines.svh"

module axi_rd_burst_ctrl #(
    parameter int C_LAT = `AXI_RD_C_LAT_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // AR channel
    input  logic                   i_ar_valid,
    input  axi_rd_pkg::ar_req_t    i_ar,
    output logic                   o_ar_ready,
    // Address generator loop
    input  axi_rd_pkg::addr_t      i_next_addr,
    output axi_rd_pkg::ar_req_t    o_cur,
    // All skid stages empty
    input  logic                   i_pipe_ready,
    // Component request port
    input  logic                   i_comp_hld,
    output logic                   o_comp_dv,
    output axi_rd_pkg::comp_req_t  o_comp_req,
    // Beat context, delayed to line up with rdata
    output logic                   o_beat_valid,
    output axi_rd_pkg::xfer_ctx_t  o_beat_ctx
);

    // Low address bits dropped for word alignment
    localparam int BW = $clog2(`AXI_RD_DW / 8);

    logic                  out_of_rst;
    logic                  active;
    axi_rd_pkg::len_t      beats_left;
    axi_rd_pkg::ar_req_t   cur;
    logic                  ar_hs;
    logic                  taken;
    logic                  last_beat;
    logic                  final_beat;

    // Index 0 is the request edge, index C_LAT lines up with rdata
    logic                  ctx_vld [0:C_LAT];
    axi_rd_pkg::xfer_ctx_t ctx_pipe [0:C_LAT];

    // ------------------------------------------------------------------------
    // AR acceptance
    // ------------------------------------------------------------------------
    assign ar_hs      = i_ar_valid && o_ar_ready;
    // Next burst may start on the same edge the current one issues its last request
    assign o_ar_ready = out_of_rst && (!active || final_beat);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst <= 1'b0;
            active     <= 1'b0;
            beats_left <= '0;
        end else begin
            out_of_rst <= 1'b1;
            if (ar_hs) begin
                active     <= 1'b1;
                beats_left <= i_ar.len;
            end else begin
                if (final_beat) begin
                    active <= 1'b0;
                end
                // Hold at zero once the burst is done
                if (taken && (beats_left != '0)) begin
                    beats_left <= beats_left - 1'b1;
                end
            end
        end
    end

    // Burst context, the address steps forward on each taken request
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            cur <= i_ar;
        end else if (taken) begin
            cur.addr <= i_next_addr;
        end
    end

    // ------------------------------------------------------------------------
    // Component request
    // ------------------------------------------------------------------------
    // Only request when every skid stage can absorb the answer
    assign o_comp_dv  = active && i_pipe_ready;
    assign taken      = o_comp_dv && !i_comp_hld;
    assign last_beat  = (beats_left == '0);
    assign final_beat = taken && last_beat;

    assign o_cur           = cur;
    assign o_comp_req.addr = {cur.addr[`AXI_RD_AW-1:BW], BW'(0)};
    assign o_comp_req.id   = cur.id;
    assign o_comp_req.size = cur.size;
    assign o_comp_req.last = last_beat;

    // ------------------------------------------------------------------------
    // Latency pipeline
    // ------------------------------------------------------------------------
    assign ctx_vld[0]       = taken;
    assign ctx_pipe[0].id   = cur.id;
    assign ctx_pipe[0].last = last_beat;

    for (genvar s = 1; s <= C_LAT; s++) begin : g_lat
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                ctx_vld[s] <= 1'b0;
            end else begin
                ctx_vld[s] <= ctx_vld[s-1];
            end
        end

        always_ff @(posedge clk) begin
            ctx_pipe[s] <= ctx_pipe[s-1];
        end
    end

    assign o_beat_valid = ctx_vld[C_LAT];
    assign o_beat_ctx   = ctx_pipe[C_LAT];

endmodule

// ==== axi_rd_skid_buffer.sv ====
`timescale 1ns/1ps

module axi_rd_skid_buffer (
    input  logic               clk,
    input  logic               rst_n,
    // Upstream side
    input  logic               i_valid,
    output logic               o_ready,
    input  axi_rd_pkg::r_rsp_t i_data,
    // Downstream side
    output logic               o_valid,
    input  logic               i_ready,
    output axi_rd_pkg::r_rsp_t o_data
);

    // Holding register and its occupancy flag
    logic               full;
    axi_rd_pkg::r_rsp_t hold_data;
    logic               capture;
    logic               drain;

    // ------------------------------------------------------------------------
    // Occupancy
    // ------------------------------------------------------------------------
    // Park an incoming beat that the downstream cannot take now
    assign capture = i_valid && !i_ready && !full;
    // Parked beat leaves once downstream accepts it
    assign drain   = full && i_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_data <= i_data;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    // Stall upstream while a beat is parked
    assign o_ready = !full;

    // Empty stage is a straight wire from input to output
    assign o_valid = full || i_valid;
    assign o_data  = full ? hold_data : i_data;

endmodule

// ==== axi_rd_sub.sv ====
`timescale 1ns/1ps

`include "axi_rd_defines.svh"

module axi_rd_sub #(
    parameter int C_LAT = `AXI_RD_C_LAT_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // AR channel
    input  logic                  i_ar_valid,
    input  axi_rd_pkg::ar_req_t   i_ar,
    output logic                  o_ar_ready,
    // R channel
    output logic                  o_r_valid,
    output axi_rd_pkg::r_rsp_t    o_r,
    input  logic                  i_r_ready,
    // Component port
    output logic                  o_comp_dv,
    output axi_rd_pkg::comp_req_t o_comp_req,
    input  logic                  i_comp_hld,
    input  logic                  i_comp_err,
    input  axi_rd_pkg::data_t     i_comp_rdata
);

    axi_rd_pkg::ar_req_t   cur;
    axi_rd_pkg::addr_t     next_addr;
    logic                  pipe_ready;
    logic                  beat_valid;
    axi_rd_pkg::xfer_ctx_t beat_ctx;

    // Skid chain, index C_LAT+1 is the R channel itself
    logic                  stg_valid [0:C_LAT+1];
    logic [C_LAT+1:0]      stg_ready;
    axi_rd_pkg::r_rsp_t    stg_data  [0:C_LAT+1];

    // ------------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------------
    axi_rd_burst_ctrl #(
        .C_LAT (C_LAT)
    ) u_burst_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ar_valid   (i_ar_valid),
        .i_ar         (i_ar),
        .o_ar_ready   (o_ar_ready),
        .i_next_addr  (next_addr),
        .o_cur        (cur),
        .i_pipe_ready (pipe_ready),
        .i_comp_hld   (i_comp_hld),
        .o_comp_dv    (o_comp_dv),
        .o_comp_req   (o_comp_req),
        .o_beat_valid (beat_valid),
        .o_beat_ctx   (beat_ctx)
    );

    // Full byte address drives the stepping so narrow beats advance correctly
    axi_rd_addr_gen u_addr_gen (
        .i_addr      (cur.addr),
        .i_size      (cur.size),
        .i_burst     (cur.burst),
        .i_len       (cur.len),
        .o_next_addr (next_addr)
    );

    // Every stage empty, R ready excluded
    assign pipe_ready = &stg_ready[C_LAT:0];

    // ------------------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------------------
    assign stg_valid[0]     = beat_valid;
    assign stg_data[0].data = i_comp_rdata;
    assign stg_data[0].id   = beat_ctx.id;
    assign stg_data[0].resp = i_comp_err ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
    assign stg_data[0].last = beat_ctx.last;

    // One stage per beat that can be in flight
    for (genvar s = 0; s <= C_LAT; s++) begin : g_skid
        axi_rd_skid_buffer u_skid (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_valid[s]),
            .o_ready (stg_ready[s]),
            .i_data  (stg_data[s]),
            .o_valid (stg_valid[s+1]),
            .i_ready (stg_ready[s+1]),
            .o_data  (stg_data[s+1])
        );
    end

    assign stg_ready[C_LAT+1] = i_r_ready;
    assign o_r_valid          = stg_valid[C_LAT+1];
    assign o_r                = stg_data[C_LAT+1];

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter time PERIOD = 40ns
) (
    output logic o_clk
);

    // Free running clock, starts low
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD / 2) o_clk = ~o_clk;

endmodule

// ==== tb_component_model.sv ====
`timescale 1ns/1ps

module tb_component_model #(
    parameter int                C_LAT    = 2,
    parameter axi_rd_pkg::data_t SCRAMBLE = 32'h5a5a_c3c3,
    parameter axi_rd_pkg::addr_t ERR_LO   = 32'h0000_0800,
    parameter axi_rd_pkg::addr_t ERR_HI   = 32'h0000_08ff
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  i_dv,
    input  axi_rd_pkg::comp_req_t i_req,
    output logic                  o_hld,
    output logic                  o_err,
    output axi_rd_pkg::data_t     o_rdata
);

    // Address and valid of each taken request with the oldest at C_LAT-1
    axi_rd_pkg::addr_t addr_pipe [0:C_LAT-1];
    logic              vld_pipe  [0:C_LAT-1];

    initial begin
        o_hld = 1'b0;
        for (int k = 0; k < C_LAT; k++) begin
            vld_pipe[k]  = 1'b0;
            addr_pipe[k] = '0;
        end
    end

    // Stall roughly one cycle in four
    always @(posedge clk) begin
        #2;
        o_hld = (($urandom % 4) == 0);
    end

    // ------------------------------------------------------------------------
    // Fixed latency answer
    // ------------------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < C_LAT; k++) begin
                vld_pipe[k]  <= 1'b0;
                addr_pipe[k] <= '0;
            end
        end else begin
            vld_pipe[0]  <= i_dv && !o_hld;
            addr_pipe[0] <= i_req.addr;
            for (int k = 1; k < C_LAT; k++) begin
                vld_pipe[k]  <= vld_pipe[k-1];
                addr_pipe[k] <= addr_pipe[k-1];
            end
        end
    end

    // Data is a scrambled copy of the word address
    assign o_rdata = addr_pipe[C_LAT-1] ^ SCRAMBLE;
    // Error only inside the window
    assign o_err   = vld_pipe[C_LAT-1] &&
                     (addr_pipe[C_LAT-1] >= ERR_LO) && (addr_pipe[C_LAT-1] <= ERR_HI);

endmodule

// ==== tb_axi_rd_sub.sv ====
`timescale 1ns/1ps

module tb_axi_rd_sub;

    localparam int                C_LAT           = 2;
    localparam int                SEED            = 32'h4fcd_25fc;
    localparam axi_rd_pkg::data_t DATA_SCRAMBLE   = 32'h5a5a_c3c3;
    localparam axi_rd_pkg::addr_t ERR_LO          = 32'h0000_0800;
    localparam axi_rd_pkg::addr_t ERR_HI          = 32'h0000_08ff;
    localparam int                NUM_DIRECTED    = 5;
    localparam int                NUM_RANDOM      = 15;
    localparam int                NUM_BURSTS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int                WATCHDOG_CYCLES = NUM_BURSTS * 300;

    logic                  clk;
    logic                  rst_n;
    logic                  i_ar_valid;
    axi_rd_pkg::ar_req_t   i_ar;
    logic                  o_ar_ready;
    logic                  o_r_valid;
    axi_rd_pkg::r_rsp_t    o_r;
    logic                  i_r_ready;
    logic                  o_comp_dv;
    axi_rd_pkg::comp_req_t o_comp_req;
    logic                  comp_hld;
    logic                  comp_err;
    axi_rd_pkg::data_t     comp_rdata;

    // Scoreboard state
    axi_rd_pkg::r_rsp_t    exp_q [$];
    axi_rd_pkg::r_rsp_t    exp_beat;
    axi_rd_pkg::comp_req_t creq_q [$];
    axi_rd_pkg::comp_req_t exp_req;
    logic                  final_req;
    int                    error_count   = 0;
    int                    beats_checked = 0;
    int                    ar_accepted   = 0;
    int                    comp_done     = 0;

    tb_clk_gen #(.PERIOD(40ns)) u_clk_gen (.o_clk(clk));

    tb_component_model #(
        .C_LAT    (C_LAT),
        .SCRAMBLE (DATA_SCRAMBLE),
        .ERR_LO   (ERR_LO),
        .ERR_HI   (ERR_HI)
    ) u_component_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_dv    (o_comp_dv),
        .i_req   (o_comp_req),
        .o_hld   (comp_hld),
        .o_err   (comp_err),
        .o_rdata (comp_rdata)
    );

    axi_rd_sub #(.C_LAT(C_LAT)) u_axi_rd_sub (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ar_valid   (i_ar_valid),
        .i_ar         (i_ar),
        .o_ar_ready   (o_ar_ready),
        .o_r_valid    (o_r_valid),
        .o_r          (o_r),
        .i_r_ready    (i_r_ready),
        .o_comp_dv    (o_comp_dv),
        .o_comp_req   (o_comp_req),
        .i_comp_hld   (comp_hld),
        .i_comp_err   (comp_err),
        .i_comp_rdata (comp_rdata)
    );

    // ------------------------------------------------------------------------
    // Expected model
    // ------------------------------------------------------------------------
    // Byte address of beat n under the AXI burst rules
    function automatic axi_rd_pkg::addr_t beat_addr(input axi_rd_pkg::ar_req_t ar, input int n);
        axi_rd_pkg::addr_t bytes;
        axi_rd_pkg::addr_t total;
        axi_rd_pkg::addr_t base;
        bytes = 32'd1 << ar.size;
        total = bytes * (32'(ar.len) + 32'd1);
        base  = (ar.addr / total) * total;
        if (ar.burst == axi_rd_pkg::BURST_INCR) begin
            // First beat may be unaligned, later ones start on size boundaries
            beat_addr = (n == 0) ? ar.addr : (ar.addr / bytes) * bytes + n * bytes;
        end else if (ar.burst == axi_rd_pkg::BURST_WRAP) begin
            beat_addr = base + ((ar.addr - base + n * bytes) % total);
        end else begin
            beat_addr = ar.addr;
        end
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %0t %s expected %h actual %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    // Queue the expected beats, then offer AR until it is taken
    task automatic send_burst(input axi_rd_pkg::addr_t addr, input axi_rd_pkg::burst_e burst,
                              input axi_rd_pkg::size_t size, input axi_rd_pkg::len_t len,
                              input axi_rd_pkg::id_t id);
        axi_rd_pkg::ar_req_t   ar;
        axi_rd_pkg::r_rsp_t    beat;
        axi_rd_pkg::comp_req_t req;
        axi_rd_pkg::addr_t     word;
        ar.addr  = addr;
        ar.burst = burst;
        ar.size  = size;
        ar.len   = len;
        ar.id    = id;
        for (int n = 0; n <= int'(len); n++) begin
            word      = beat_addr(ar, n) & ~32'd3;
            beat.data = word ^ DATA_SCRAMBLE;
            beat.id   = id;
            beat.resp = (word >= ERR_LO && word <= ERR_HI) ?
                        axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
            beat.last = (n == int'(len));
            exp_q.push_back(beat);
            req.addr = word;
            req.id   = id;
            req.size = size;
            req.last = (n == int'(len));
            creq_q.push_back(req);
        end
        i_ar_valid = 1'b1;
        i_ar       = ar;
        do @(negedge clk); while (!o_ar_ready);
        @(posedge clk);
        #2;
        i_ar_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------------
    // R payload must hold while stalled
    property r_hold_p;
        @(posedge clk) disable iff (!rst_n)
            (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r));
    endproperty

    assert property (r_hold_p) else begin
        $display("R channel dropped valid or changed payload while stalled at %0t", $time);
        error_count++;
    end

    // Random R back-pressure
    always @(posedge clk) begin
        #2;
        i_r_ready = (($urandom % 4) != 0);
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!o_ar_ready && !o_r_valid && !o_comp_dv) else begin
                $display("Handshake output high during reset at %0t", $time);
                error_count++;
            end
        end else begin
            // Each taken component request against the burst rules
            final_req = 1'b0;
            if (o_comp_dv && !comp_hld) begin
                if (creq_q.size() == 0) begin
                    $display("Component request taken with none expected at %0t", $time);
                    error_count++;
                end else begin
                    exp_req = creq_q.pop_front();
                    check_field("o_comp_req.addr", exp_req.addr, o_comp_req.addr);
                    check_field("o_comp_req.id", 32'(exp_req.id), 32'(o_comp_req.id));
                    check_field("o_comp_req.size", 32'(exp_req.size), 32'(o_comp_req.size));
                    check_field("o_comp_req.last", 32'(exp_req.last), 32'(o_comp_req.last));
                    final_req = exp_req.last;
                end
            end
            // New AR only once the previous burst issues its final request
            if (i_ar_valid && o_ar_ready) begin
                assert (ar_accepted == comp_done || final_req) else begin
                    $display("AR accepted during an active burst at %0t", $time);
                    error_count++;
                end
                ar_accepted++;
            end
            if (final_req) begin
                comp_done++;
            end
            if (o_r_valid && i_r_ready) begin
                if (exp_q.size() == 0) begin
                    $display("R beat arrived with none expected at %0t", $time);
                    error_count++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_field("o_r.data", exp_beat.data, o_r.data);
                    check_field("o_r.id", 32'(exp_beat.id), 32'(o_r.id));
                    check_field("o_r.resp", 32'(exp_beat.resp), 32'(o_r.resp));
                    check_field("o_r.last", 32'(exp_beat.last), 32'(o_r.last));
                    beats_checked++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d beats still expected", WATCHDOG_CYCLES,
                 exp_q.size());
        $display("tests failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int                 kind;
        axi_rd_pkg::addr_t  r_addr;
        axi_rd_pkg::size_t  r_size;
        axi_rd_pkg::len_t   r_len;
        axi_rd_pkg::id_t    r_id;
        axi_rd_pkg::burst_e r_burst;
        void'($urandom(SEED));
        rst_n      = 1'b0;
        i_ar_valid = 1'b0;
        i_ar       = '0;
        i_r_ready  = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (o_ar_ready) else begin
            $display("AR not ready while idle after reset at %0t", $time);
            error_count++;
        end
        @(posedge clk);
        #2;
        // INCR, WRAP from mid window, FIXED, narrow INCR, error window crossing
        send_burst(32'h0000_0100, axi_rd_pkg::BURST_INCR, 3'd2, 8'd3, 4'h1);
        send_burst(32'h0000_0208, axi_rd_pkg::BURST_WRAP, 3'd2, 8'd3, 4'h2);
        send_burst(32'h0000_0304, axi_rd_pkg::BURST_FIXED, 3'd2, 8'd2, 4'h3);
        send_burst(32'h0000_0402, axi_rd_pkg::BURST_INCR, 3'd0, 8'd5, 4'h4);
        send_burst(32'h0000_08f8, axi_rd_pkg::BURST_INCR, 3'd2, 8'd3, 4'h5);
        for (int b = 0; b < NUM_RANDOM; b++) begin
            r_size = axi_rd_pkg::size_t'($urandom % 3);
            r_addr = axi_rd_pkg::addr_t'($urandom % 32'h1000);
            r_id   = axi_rd_pkg::id_t'($urandom);
            kind   = $urandom % 3;
            if (kind == 0) begin
                // Wrap needs a size aligned start and 2, 4, 8 or 16 beats
                r_burst = axi_rd_pkg::BURST_WRAP;
                r_len   = axi_rd_pkg::len_t'((2 << ($urandom % 4)) - 1);
                r_addr  = r_addr & ~((32'd1 << r_size) - 32'd1);
            end else if (kind == 1) begin
                r_burst = axi_rd_pkg::BURST_FIXED;
                r_len   = axi_rd_pkg::len_t'($urandom % 4);
            end else begin
                r_burst = axi_rd_pkg::BURST_INCR;
                r_len   = axi_rd_pkg::len_t'($urandom % 16);
            end
            send_burst(r_addr, r_burst, r_size, r_len, r_id);
        end
        while (exp_q.size() != 0) @(negedge clk);
        // Idle tail catches any extra beat
        repeat (20) @(posedge clk);
        $display("Summary: %0d beats checked, %0d errors", beats_checked, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
axi_rd_pkg.sv
axi_rd_addr_gen.sv
axi_rd_burst_ctrl.sv
axi_rd_skid_buffer.sv
axi_rd_sub.sv
tb_clk_gen.sv
tb_component_model.sv
tb_axi_rd_sub.sv
